/* common/sobel_nms_defines.svh */
`ifndef SOBEL_NMS_DEFINES_SVH
`define SOBEL_NMS_DEFINES_SVH

// pixel and patch geometry
`define PIX_W      8
`define PATCH_PIX  16

// gradient and magnitude widths
`define GRAD_W     11
`define MAG_W      12

// windows per patch, batches per run
`define SLOTS      4
`define DEPTH_INIT 4

// direction thresholds in units of 1/128
`define FRAC_W     7
`define COEF_HI    309
`define COEF_LO    53

`endif

/* common/pixel_pkg.sv */
`default_nettype none

`include "sobel_nms_defines.svh"

package pixel_pkg;

    // one unsigned input pixel
    typedef logic [`PIX_W-1:0] pixel_t;

    // full input patch, row-major, index 0 is top-left
    typedef pixel_t [`PATCH_PIX-1:0] patch_t;

    // signed gradient component, wide enough for 4 x 255
    typedef logic signed [`GRAD_W-1:0] grad_t;

endpackage

`default_nettype wire

/* common/nms_pkg.sv */
`default_nettype none

`include "sobel_nms_defines.svh"

package nms_pkg;

    // |gx| + |gy|
    typedef logic [`MAG_W-1:0] mag_t;

    // quantized gradient direction
    typedef enum logic [1:0] {
        DIR_VERT = 2'd0,
        DIR_DIAG = 2'd1,
        DIR_HORZ = 2'd2,
        DIR_ANTI = 2'd3
    } dir_e;

    // window position inside the 2x2 block
    typedef logic [$clog2(`SLOTS)-1:0] slot_t;

endpackage

`default_nettype wire

/* common/grad_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one window's polar gradient, valid-only handshake
interface grad_if;
    import nms_pkg::*;

    logic  valid;
    slot_t slot;
    mag_t  mag;
    dir_e  dir;

    // quantizer side
    modport src (
        output valid,
        output slot,
        output mag,
        output dir
    );

    // suppression side
    modport dst (
        input valid,
        input slot,
        input mag,
        input dir
    );

endinterface

`default_nettype wire

/* sobel/sobel_window_seq.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sobel_nms_defines.svh"

module sobel_window_seq (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_in_valid,
    input  pixel_pkg::patch_t        i_patch,
    output logic                     o_win_valid,
    output nms_pkg::slot_t           o_win_slot,
    output pixel_pkg::pixel_t [8:0]  o_window
);
    import pixel_pkg::*;
    import nms_pkg::*;

    localparam int    ROW       = 4;
    localparam slot_t LAST_SLOT = slot_t'(`SLOTS - 1);

    patch_t     patch_r;
    slot_t      slot_r;
    logic       busy_r;
    logic [3:0] base;

    // ------------------------------
    // patch capture
    always_ff @(posedge i_clk) begin
        if (i_in_valid) begin
            patch_r <= i_patch;
        end
    end

    // ------------------------------
    // window sequencing, slots 0..3 after each load
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            busy_r <= 1'b0;
            slot_r <= '0;
        end else if (i_in_valid) begin
            busy_r <= 1'b1;
            slot_r <= '0;
        end else if (busy_r) begin
            slot_r <= slot_r + slot_t'(1);
            if (slot_r == LAST_SLOT) begin
                busy_r <= 1'b0;
            end
        end
    end

    // top-left pixel of the window: 0, 1, 4, 5
    assign base = {1'b0, slot_r[1], 1'b0, slot_r[0]};

    // pick the 3x3 window out of the 4x4 patch
    always_comb begin
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                o_window[r*3 + c] = patch_r[base + 4'(r*ROW + c)];
            end
        end
    end

    assign o_win_valid = busy_r;
    assign o_win_slot  = slot_r;

endmodule

`default_nettype wire

/* sobel/sobel_gradient.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sobel_nms_defines.svh"

module sobel_gradient (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_win_valid,
    input  nms_pkg::slot_t           i_win_slot,
    input  pixel_pkg::pixel_t [8:0]  i_window,
    output logic                     o_valid,
    output nms_pkg::slot_t           o_slot,
    output pixel_pkg::grad_t         o_gx,
    output pixel_pkg::grad_t         o_gy
);
    import pixel_pkg::*;
    import nms_pkg::*;

    logic  s1_valid;
    slot_t s1_slot;
    grad_t s1_px [3];
    grad_t s1_py [3];

    // zero-extend a pixel into the signed gradient width
    function automatic grad_t pix(input pixel_t p);
        return {{(`GRAD_W - `PIX_W){1'b0}}, p};
    endfunction

    // ------------------------------
    // valid pipe, two stages
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            s1_valid <= 1'b0;
            o_valid  <= 1'b0;
        end else begin
            s1_valid <= i_win_valid;
            o_valid  <= s1_valid;
        end
    end

    // ------------------------------
    // stage 1: partial sums
    // x kernel taken row by row, y kernel column by column
    always_ff @(posedge i_clk) begin
        if (i_win_valid) begin
            s1_slot  <= i_win_slot;
            s1_px[0] <= pix(i_window[2]) - pix(i_window[0]);
            s1_px[1] <= (pix(i_window[5]) - pix(i_window[3])) <<< 1;
            s1_px[2] <= pix(i_window[8]) - pix(i_window[6]);
            s1_py[0] <= pix(i_window[6]) - pix(i_window[0]);
            s1_py[1] <= (pix(i_window[7]) - pix(i_window[1])) <<< 1;
            s1_py[2] <= pix(i_window[8]) - pix(i_window[2]);
        end
    end

    // ------------------------------
    // stage 2: full gradients
    always_ff @(posedge i_clk) begin
        if (s1_valid) begin
            o_slot <= s1_slot;
            o_gx   <= s1_px[0] + s1_px[1] + s1_px[2];
            o_gy   <= s1_py[0] + s1_py[1] + s1_py[2];
        end
    end

endmodule

`default_nettype wire

/* sobel/gradient_polar.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sobel_nms_defines.svh"

module gradient_polar (
    input  logic              i_valid,
    input  nms_pkg::slot_t    i_slot,
    input  pixel_pkg::grad_t  i_gx,
    input  pixel_pkg::grad_t  i_gy,
    grad_if.src               o_grad
);
    import nms_pkg::*;

    // room for gx * 309 with sign
    localparam int PROD_W = `GRAD_W + `FRAC_W + 3;

    localparam logic signed [PROD_W-1:0] K_HI = PROD_W'(`COEF_HI);
    localparam logic signed [PROD_W-1:0] K_LO = PROD_W'(`COEF_LO);

    logic signed [PROD_W-1:0] gx_w;
    logic signed [PROD_W-1:0] gy_s;
    logic signed [PROD_W-1:0] t_hi;
    logic signed [PROD_W-1:0] t_lo;
    logic                     gx_neg;
    logic [3:0]               above;
    mag_t                     abs_gx;
    mag_t                     abs_gy;
    dir_e                     dir;

    // y above the line t when gx >= 0, below it when gx < 0
    function automatic logic over(input logic neg,
                                  input logic signed [PROD_W-1:0] y,
                                  input logic signed [PROD_W-1:0] t);
        return neg ? (y < t) : (y > t);
    endfunction

    // ------------------------------
    // magnitude
    assign abs_gx = i_gx[`GRAD_W-1] ? mag_t'(-i_gx) : mag_t'(i_gx);
    assign abs_gy = i_gy[`GRAD_W-1] ? mag_t'(-i_gy) : mag_t'(i_gy);

    // ------------------------------
    // direction, gy*128 against gx scaled by tan(67.5) and tan(22.5)
    assign gx_w   = PROD_W'(i_gx);
    assign gy_s   = PROD_W'(i_gy) <<< `FRAC_W;
    assign t_hi   = gx_w * K_HI;
    assign t_lo   = gx_w * K_LO;
    assign gx_neg = i_gx[`GRAD_W-1];

    assign above = {over(gx_neg, gy_s, t_hi),
                    over(gx_neg, gy_s, t_lo),
                    over(gx_neg, gy_s, -t_lo),
                    over(gx_neg, gy_s, -t_hi)};

    always_comb begin
        case (above)
            4'b1111, 4'b0000: dir = DIR_VERT;
            4'b0111:          dir = DIR_DIAG;
            4'b0011:          dir = DIR_HORZ;
            4'b0001:          dir = DIR_ANTI;
            // inconsistent flags only on threshold edges
            default:          dir = DIR_VERT;
        endcase
    end

    assign o_grad.valid = i_valid;
    assign o_grad.slot  = i_slot;
    assign o_grad.mag   = abs_gx + abs_gy;
    assign o_grad.dir   = dir;

endmodule

`default_nettype wire

/* nms/nms_output.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sobel_nms_defines.svh"

module nms_output (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  logic                           i_rst_eng,
    input  logic                           i_set_eng,
    grad_if.dst                            i_grad,
    output nms_pkg::mag_t [`SLOTS-1:0]     o_data,
    output logic                           o_out_valid,
    output logic                           o_done
);
    import nms_pkg::*;

    localparam int    DEPTH_W   = $clog2(`DEPTH_INIT + 1);
    localparam slot_t LAST_SLOT = slot_t'(`SLOTS - 1);

    mag_t               mag_r [`SLOTS];
    dir_e               dir_r [`SLOTS];
    mag_t [`SLOTS-1:0]  sup;
    mag_t [`SLOTS-1:0]  data_r;
    logic               blk_done_r;
    logic               out_valid_r;
    logic [DEPTH_W-1:0] depth_r;

    // ------------------------------
    // slot collection
    always_ff @(posedge i_clk) begin
        if (i_grad.valid) begin
            mag_r[i_grad.slot] <= i_grad.mag;
            dir_r[i_grad.slot] <= i_grad.dir;
        end
    end

    // ------------------------------
    // 2x2 suppression
    //   0 1
    //   2 3
    // partner is slot xor 2 (vert), xor 1 (horz), xor 3 (diagonals)
    always_comb begin
        slot_t sv;
        logic  keep;
        for (int s = 0; s < `SLOTS; s++) begin
            sv = slot_t'(s);
            case (dir_r[s])
                DIR_VERT: keep = mag_r[s] >= mag_r[sv ^ 2'b10];
                DIR_HORZ: keep = mag_r[s] >= mag_r[sv ^ 2'b01];
                // only 0 and 3 sit on the main diagonal
                DIR_DIAG: keep = (sv[0] != sv[1]) || (mag_r[s] >= mag_r[sv ^ 2'b11]);
                DIR_ANTI: keep = (sv[0] == sv[1]) || (mag_r[s] >= mag_r[sv ^ 2'b11]);
                default:  keep = 1'b1;
            endcase
            sup[s] = keep ? mag_r[s] : '0;
        end
    end

    // ------------------------------
    // output registers and batch countdown
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            blk_done_r  <= 1'b0;
            out_valid_r <= 1'b0;
            data_r      <= '0;
            depth_r     <= '0;
        end else begin
            blk_done_r  <= i_grad.valid && (i_grad.slot == LAST_SLOT);
            out_valid_r <= blk_done_r;
            if (blk_done_r) begin
                data_r <= sup;
            end
            // rst_eng wins over set_eng
            if (i_rst_eng) begin
                depth_r <= '0;
            end else if (i_set_eng) begin
                depth_r <= DEPTH_W'(`DEPTH_INIT);
            end else if (blk_done_r && (depth_r != '0)) begin
                depth_r <= depth_r - DEPTH_W'(1);
            end
        end
    end

    assign o_data      = data_r;
    assign o_out_valid = out_valid_r;
    assign o_done      = out_valid_r && (depth_r == '0);

endmodule

`default_nettype wire

/* source/sobel_nms_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sobel_nms_defines.svh"

module sobel_nms_engine (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_rst_eng,
    input  logic               i_set_eng,
    input  logic               i_in_valid,
    input  pixel_pkg::pixel_t  i_data0,
    input  pixel_pkg::pixel_t  i_data1,
    input  pixel_pkg::pixel_t  i_data2,
    input  pixel_pkg::pixel_t  i_data3,
    input  pixel_pkg::pixel_t  i_data4,
    input  pixel_pkg::pixel_t  i_data5,
    input  pixel_pkg::pixel_t  i_data6,
    input  pixel_pkg::pixel_t  i_data7,
    input  pixel_pkg::pixel_t  i_data8,
    input  pixel_pkg::pixel_t  i_data9,
    input  pixel_pkg::pixel_t  i_data10,
    input  pixel_pkg::pixel_t  i_data11,
    input  pixel_pkg::pixel_t  i_data12,
    input  pixel_pkg::pixel_t  i_data13,
    input  pixel_pkg::pixel_t  i_data14,
    input  pixel_pkg::pixel_t  i_data15,
    output nms_pkg::mag_t      o_data0,
    output nms_pkg::mag_t      o_data1,
    output nms_pkg::mag_t      o_data2,
    output nms_pkg::mag_t      o_data3,
    output logic               o_out_valid,
    output logic               o_done
);
    import pixel_pkg::*;
    import nms_pkg::*;

    patch_t            patch;
    logic              win_valid;
    slot_t             win_slot;
    pixel_t [8:0]      window;
    logic              grad_valid;
    slot_t             grad_slot;
    grad_t             gx;
    grad_t             gy;
    mag_t [`SLOTS-1:0] data;

    grad_if u_grad_if ();

    // pixel 0 lands at index 0
    assign patch = {i_data15, i_data14, i_data13, i_data12,
                    i_data11, i_data10, i_data9,  i_data8,
                    i_data7,  i_data6,  i_data5,  i_data4,
                    i_data3,  i_data2,  i_data1,  i_data0};

    sobel_window_seq u_sobel_window_seq (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_in_valid  (i_in_valid),
        .i_patch     (patch),
        .o_win_valid (win_valid),
        .o_win_slot  (win_slot),
        .o_window    (window)
    );

    sobel_gradient u_sobel_gradient (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_win_valid (win_valid),
        .i_win_slot  (win_slot),
        .i_window    (window),
        .o_valid     (grad_valid),
        .o_slot      (grad_slot),
        .o_gx        (gx),
        .o_gy        (gy)
    );

    gradient_polar u_gradient_polar (
        .i_valid (grad_valid),
        .i_slot  (grad_slot),
        .i_gx    (gx),
        .i_gy    (gy),
        .o_grad  (u_grad_if.src)
    );

    nms_output u_nms_output (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_rst_eng   (i_rst_eng),
        .i_set_eng   (i_set_eng),
        .i_grad      (u_grad_if.dst),
        .o_data      (data),
        .o_out_valid (o_out_valid),
        .o_done      (o_done)
    );

    assign o_data0 = data[0];
    assign o_data1 = data[1];
    assign o_data2 = data[2];
    assign o_data3 = data[3];

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 5,
    parameter int DRIVE_DELAY  = 2
) (
    output logic o_clk,
    output logic o_rst_n
);
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // reset low for RESET_CYCLES rising edges
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #DRIVE_DELAY;
        o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* testbench/sobel_nms_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module sobel_nms_asserts (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_in_valid,
    input logic i_out_valid,
    input logic i_done
);
    int unsigned latency_fails = 0;
    int unsigned pulse_fails   = 0;
    int unsigned done_fails    = 0;

    // ------------------------------
    // accepted batch leaves 8 edges later
    property p_latency;
        @(posedge i_clk) disable iff (!i_rst_n)
            i_in_valid |-> ##8 i_out_valid;
    endproperty

    // output valid is a single-cycle pulse
    property p_single_pulse;
        @(posedge i_clk) disable iff (!i_rst_n)
            i_out_valid |=> !i_out_valid;
    endproperty

    // done only rides on an output
    property p_done_with_valid;
        @(posedge i_clk) disable iff (!i_rst_n)
            i_done |-> i_out_valid;
    endproperty

    a_latency: assert property (p_latency) else begin
        $error("output valid missing 8 cycles after input valid");
        latency_fails++;
    end

    a_single_pulse: assert property (p_single_pulse) else begin
        $error("output valid stayed high for two cycles");
        pulse_fails++;
    end

    a_done_with_valid: assert property (p_done_with_valid) else begin
        $error("done high without output valid");
        done_fails++;
    end

endmodule

bind sobel_nms_engine sobel_nms_asserts u_sobel_nms_asserts (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_in_valid  (i_in_valid),
    .i_out_valid (o_out_valid),
    .i_done      (o_done)
);

`default_nettype wire

/* testbench/tb_sobel_nms_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sobel_nms_defines.svh"

module tb_sobel_nms_engine;
    import pixel_pkg::*;
    import nms_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int DRIVE_DELAY = 2;
    localparam int NUM_BATCHES = 50;

    logic          clk;
    logic          rst_n;
    logic          rst_eng;
    logic          set_eng;
    logic          in_valid;
    pixel_t        din [16];
    mag_t          dout [4];
    logic          out_valid;
    logic          done;

    integer      seed        = 70;
    int          cycle_count = 0;
    int          depth_model = 0;
    logic [47:0] exp_data [$];
    logic        exp_done [$];
    int          exp_cycle [$];
    string       exp_test [$];

    tb_clock #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (5),
        .DRIVE_DELAY  (DRIVE_DELAY)
    ) u_tb_clock (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    sobel_nms_engine u_sobel_nms_engine (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_rst_eng   (rst_eng),
        .i_set_eng   (set_eng),
        .i_in_valid  (in_valid),
        .i_data0     (din[0]),
        .i_data1     (din[1]),
        .i_data2     (din[2]),
        .i_data3     (din[3]),
        .i_data4     (din[4]),
        .i_data5     (din[5]),
        .i_data6     (din[6]),
        .i_data7     (din[7]),
        .i_data8     (din[8]),
        .i_data9     (din[9]),
        .i_data10    (din[10]),
        .i_data11    (din[11]),
        .i_data12    (din[12]),
        .i_data13    (din[13]),
        .i_data14    (din[14]),
        .i_data15    (din[15]),
        .o_data0     (dout[0]),
        .o_data1     (dout[1]),
        .o_data2     (dout[2]),
        .o_data3     (dout[3]),
        .o_out_valid (out_valid),
        .o_done      (done)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic fail_now();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
        assert (got === exp) else begin
            $display("ERROR %s expected %0h got %0h", name, exp, got);
            fail_now();
        end
    endtask

    // ------------------------------
    // reference model
    function automatic int px(input patch_t p, input int k);
        return int'(p[k]);
    endfunction

    // sector from four threshold flags with bit 0 on the -309 line
    function automatic int sector(input int gx, input int gy);
        int         y;
        int         lim [4];
        logic [3:0] f;
        y      = gy * (1 << `FRAC_W);
        lim[3] = gx * `COEF_HI;
        lim[2] = gx * `COEF_LO;
        lim[1] = -gx * `COEF_LO;
        lim[0] = -gx * `COEF_HI;
        for (int k = 0; k < 4; k++) begin
            f[k] = (gx < 0) ? (y < lim[k]) : (y > lim[k]);
        end
        case (f)
            4'b0111: return 1;
            4'b0011: return 2;
            4'b0001: return 3;
            default: return 0;
        endcase
    endfunction

    // neighbour inside the 2x2 block or -1 if there is none
    function automatic int partner(input int dir, input int s);
        case (dir)
            0: return s ^ 2;
            2: return s ^ 1;
            1: return (s == 0 || s == 3) ? 3 - s : -1;
            default: return (s == 1 || s == 2) ? 3 - s : -1;
        endcase
    endfunction

    function automatic logic [47:0] model_outputs(input patch_t p);
        int          base;
        int          gx;
        int          gy;
        int          nb;
        int          mag [4];
        int          dir [4];
        logic [47:0] res;
        res = '0;
        for (int s = 0; s < 4; s++) begin
            base   = (s / 2) * 4 + (s % 2);
            gx     = px(p, base + 2) - px(p, base) + 2 * (px(p, base + 6) - px(p, base + 4))
                     + px(p, base + 10) - px(p, base + 8);
            gy     = px(p, base + 8) - px(p, base) + 2 * (px(p, base + 9) - px(p, base + 1))
                     + px(p, base + 10) - px(p, base + 2);
            mag[s] = (gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy);
            dir[s] = sector(gx, gy);
        end
        for (int s = 0; s < 4; s++) begin
            nb = partner(dir[s], s);
            if (nb < 0 || mag[s] >= mag[nb]) begin
                res[s*12 +: 12] = 12'(mag[s]);
            end
        end
        return res;
    endfunction

    // flat, horizontal, vertical, diagonal and anti-diagonal ramps
    function automatic patch_t shaped_patch(input int kind);
        patch_t p;
        int     v;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                case (kind)
                    0: v = 90;
                    1: v = c * c * 20;
                    2: v = r * r * 20;
                    3: v = (r + c) * (r + c) * 7;
                    default: v = (c + 3 - r) * (c + 3 - r) * 7;
                endcase
                p[r * 4 + c] = 8'(v);
            end
        end
        return p;
    endfunction

    // ------------------------------
    // stimulus helpers
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic send_patch(input string name, input patch_t p, input int gap);
        for (int k = 0; k < 16; k++) begin
            din[k] = p[k];
        end
        in_valid = 1'b1;
        if (depth_model > 0) begin
            depth_model--;
        end
        exp_data.push_back(model_outputs(p));
        exp_done.push_back(depth_model == 0);
        // sampled at the next edge and seen at the negedge 7 edges later
        exp_cycle.push_back(cycle_count + 8);
        exp_test.push_back(name);
        next_cycle();
        in_valid = 1'b0;
        repeat (gap - 1) next_cycle();
    endtask

    task automatic control_pulse(input logic set, input logic clr);
        set_eng = set;
        rst_eng = clr;
        if (clr) begin
            depth_model = 0;
        end else if (set) begin
            depth_model = `DEPTH_INIT;
        end
        next_cycle();
        set_eng = 1'b0;
        rst_eng = 1'b0;
    endtask

    task automatic drain();
        while (exp_data.size() != 0) begin
            next_cycle();
        end
        next_cycle();
    endtask

    // ------------------------------
    // output monitor sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            assert (exp_data.size() > 0) else begin
                $display("output valid rose with no batch outstanding");
                fail_now();
            end
            check_value({exp_test[0], " data"}, 64'(exp_data[0]),
                        64'({dout[3], dout[2], dout[1], dout[0]}));
            check_value({exp_test[0], " done"}, 64'(exp_done[0]), 64'(done));
            check_value({exp_test[0], " latency"}, 64'(exp_cycle[0]), 64'(cycle_count));
            void'(exp_data.pop_front());
            void'(exp_done.pop_front());
            void'(exp_cycle.pop_front());
            void'(exp_test.pop_front());
        end
    end

    // watchdog
    initial begin
        #(CLK_PERIOD * (40 * NUM_BATCHES + 200));
        $display("timeout: the engine stopped producing outputs");
        fail_now();
    end

    initial begin
        patch_t p;
        rst_eng  = 1'b0;
        set_eng  = 1'b0;
        in_valid = 1'b0;
        for (int k = 0; k < 16; k++) begin
            din[k] = '0;
        end
        wait (rst_n === 1'b1);
        next_cycle();

        check_value("reset", '0, 64'({out_valid, done, dout[3], dout[2], dout[1], dout[0]}));

        send_patch("flat", shaped_patch(0), 4);
        drain();

        // one ramp per direction sector
        for (int kind = 1; kind < 5; kind++) begin
            send_patch("directed", shaped_patch(kind), 12);
        end
        drain();

        // back to back at 4 cycles so two batches are in flight
        for (int n = 0; n < 40; n++) begin
            for (int k = 0; k < 16; k++) begin
                p[k] = 8'($random(seed));
            end
            send_patch("random", p, 4);
        end
        drain();

        // ------------------------------
        // batch countdown
        control_pulse(1'b1, 1'b0);
        for (int n = 0; n < 4; n++) begin
            send_patch("countdown", shaped_patch(n + 1), 4);
        end
        drain();
        control_pulse(1'b1, 1'b0);
        control_pulse(1'b0, 1'b1);
        send_patch("cleared", shaped_patch(3), 4);
        drain();

        if (u_sobel_nms_engine.u_sobel_nms_asserts.latency_fails == 0
            && u_sobel_nms_engine.u_sobel_nms_asserts.pulse_fails == 0
            && u_sobel_nms_engine.u_sobel_nms_asserts.done_fails == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("bound assertions failed during the run");
            fail_now();
        end
    end

endmodule

`default_nettype wire

/* sobel_nms_engine.f */
+incdir+common
common/pixel_pkg.sv
common/nms_pkg.sv
common/grad_if.sv
sobel/sobel_window_seq.sv
sobel/sobel_gradient.sv
sobel/gradient_polar.sv
nms/nms_output.sv
source/sobel_nms_engine.sv
testbench/tb_clock.sv
testbench/sobel_nms_asserts.sv
testbench/tb_sobel_nms_engine.sv

/* Makefile */
# Verilator build and run for the Sobel NMS engine

SIM  := obj_dir/Vtb_sobel_nms_engine
SRCS := $(shell grep -v '^+' sobel_nms_engine.f) $(wildcard common/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): sobel_nms_engine.f $(SRCS)
	verilator --binary --timing --assert -f sobel_nms_engine.f \
		--top-module tb_sobel_nms_engine -Mdir obj_dir

# verdict comes from the log
run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
